//--- common/r2_consts.svh
`ifndef R2_CONSTS_SVH
`define R2_CONSTS_SVH

// Frame geometry.
`define R2_COLS 8
`define R2_ROWS 4

// Pixel and integral widths.
// 16 bits covers the full frame at full scale.
`define R2_PIX_W 8
`define R2_SUM_W 16

`endif

//--- common/r2_if.sv
`timescale 1ns/1ps
`default_nettype none

// Sequencing signals between controller and datapath.
interface r2_ctrl_if import r2_pkg::*; ();

    logic run;
    logic clear;
    col_t col;
    logic row_first;
    logic frame_end;
    logic step;
    logic out_fire;

    modport ctrl (
        output run, clear, col, row_first, frame_end,
        input  step, out_fire
    );

    modport dp (
        input  run, col, row_first, frame_end,
        output step, out_fire
    );

endinterface

// Port into the one-row integral store.
interface r2_line_if import r2_pkg::*; ();

    col_t addr;
    sum_t wdata;
    logic we;
    sum_t rdata;

    modport user (output addr, wdata, we, input rdata);

    modport mem (input addr, wdata, we, output rdata);

endinterface

`default_nettype wire

//--- common/r2_pkg.sv
`default_nettype none

`include "r2_consts.svh"

package r2_pkg;

    typedef logic [`R2_PIX_W-1:0] pix_t;
    typedef logic [`R2_SUM_W-1:0] sum_t;

    // Indices sized to the frame.
    typedef logic [$clog2(`R2_COLS)-1:0] col_t;
    typedef logic [$clog2(`R2_ROWS)-1:0] row_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RUN,
        DRAIN,
        FINISH
    } r2_state_t;

endpackage

`default_nettype wire

//--- filelist.f
+incdir+common
common/r2_pkg.sv
common/r2_if.sv
r2/r2_controller.sv
r2/r2_line_buffer.sv
r2/r2_accum.sv
verilog/r2_top.sv
tests/r2_chk.sv
tests/r2_tb.sv

//--- r2/r2_accum.sv
`timescale 1ns/1ps
`default_nettype none

module r2_accum import r2_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    r2_ctrl_if.dp    ctl,
    r2_line_if.user  line,
    input  logic     pix_valid,
    output logic     pix_ready,
    input  pix_t     pix_data,
    output logic     sum_valid,
    input  logic     sum_ready,
    output sum_t     sum_data,
    output logic     sum_last
);

    sum_t row_sum;
    sum_t row_next;
    sum_t sum_next;
    sum_t out_data;
    logic out_valid;
    logic out_last;

    // Running sum of this row, restarted at column 0.
    assign row_next = (ctl.row_first ? '0 : row_sum) + sum_t'(pix_data);
    assign sum_next = row_next + line.rdata;

    // Take a pixel when the output slot is free or draining this cycle.
    assign pix_ready    = ctl.run && (!out_valid || sum_ready);
    assign ctl.step     = pix_valid && pix_ready;
    assign ctl.out_fire = out_valid && sum_ready;

    always_ff @(posedge clk) begin
        if (ctl.step) begin
            row_sum  <= row_next;
            out_data <= sum_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (ctl.step) begin
            out_valid <= 1'b1;
            out_last  <= ctl.frame_end;
        end else if (ctl.out_fire) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    // Integral of this row becomes the previous row for the next one.
    assign line.addr  = ctl.col;
    assign line.wdata = sum_next;
    assign line.we    = ctl.step;

    assign sum_valid = out_valid;
    assign sum_data  = out_data;
    assign sum_last  = out_last;

endmodule

`default_nettype wire

//--- r2/r2_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "r2_consts.svh"

module r2_controller import r2_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output logic      busy,
    output logic      done,
    r2_ctrl_if.ctrl   ctl
);

    r2_state_t state;
    r2_state_t state_next;

    col_t col_cnt;
    row_t row_cnt;
    logic col_last;
    logic row_last;

    assign col_last = (col_cnt == col_t'(`R2_COLS - 1));
    assign row_last = (row_cnt == row_t'(`R2_ROWS - 1));

    // Column and row position of the next pixel.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (state == CLEAR) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (ctl.step) begin
            if (col_last) begin
                col_cnt <= '0;
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = CLEAR;
                end
            end
            CLEAR: begin
                state_next = RUN;
            end
            RUN: begin
                // Last pixel taken, wait for its sum to leave.
                if (ctl.step && ctl.frame_end) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                if (ctl.out_fire) begin
                    state_next = FINISH;
                end
            end
            FINISH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign ctl.run       = (state == RUN);
    assign ctl.clear     = (state == CLEAR);
    assign ctl.col       = col_cnt;
    assign ctl.row_first = (col_cnt == '0);
    assign ctl.frame_end = col_last && row_last;

    assign busy = (state != IDLE);
    assign done = (state == FINISH);

endmodule

`default_nettype wire

//--- r2/r2_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "r2_consts.svh"

module r2_line_buffer import r2_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    r2_line_if.mem  line
);

    sum_t               mem [`R2_COLS];
    logic [`R2_COLS-1:0] valid;

    // One flag per column, dropped together at frame start.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (clear) begin
            valid <= '0;
        end else if (line.we) begin
            valid[line.addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line.we) begin
            mem[line.addr] <= line.wdata;
        end
    end

    // Row above the first row reads as zero.
    assign line.rdata = valid[line.addr] ? mem[line.addr] : '0;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module r2_tb -f filelist.f \
    -o r2_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/r2_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tests/r2_chk.sv
`timescale 1ns/1ps
`default_nettype none

module r2_chk import r2_pkg::*; (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic pix_ready,
    input logic sum_valid,
    input logic sum_ready,
    input sum_t sum_data,
    input logic sum_last
);

    // Read by the testbench at the end of the run.
    int fail_cnt = 0;

    // Stalled output must not move.
    a_sum_hold: assert property (@(posedge clk) disable iff (rst)
        (sum_valid && !sum_ready) |=> (sum_valid && $stable(sum_data) && $stable(sum_last)))
    else begin
        fail_cnt++;
        $error("output stream changed while stalled");
    end

    a_ready_busy: assert property (@(posedge clk) disable iff (rst)
        pix_ready |-> busy)
    else begin
        fail_cnt++;
        $error("pix_ready high while not busy");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
    else begin
        fail_cnt++;
        $error("done held longer than one cycle");
    end

endmodule

bind r2_top r2_chk u_chk (.*);

`default_nettype wire

//--- tests/r2_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "r2_consts.svh"

module r2_tb import r2_pkg::*; ();

    localparam int NPIX = `R2_COLS * `R2_ROWS;
    localparam int NCASES = 6;
    localparam int VALID_GAP = 20;
    localparam int CYCLE_LIMIT = 4 * NPIX * NCASES + 50 * NCASES;

    typedef enum {PAT_CONST, PAT_RAMP, PAT_RANDOM} pat_t;

    typedef struct {
        string name;
        pat_t  kind;
        pix_t  value;
        int    stall;
    } case_t;

    logic clk;
    logic rst;
    logic start;
    logic busy;
    logic done;
    logic pix_valid;
    logic pix_ready;
    pix_t pix_data;
    logic sum_valid;
    logic sum_ready;
    sum_t sum_data;
    logic sum_last;

    case_t cases [NCASES];
    pix_t  pixels [NPIX];
    sum_t  expected [NPIX];
    int    errors;
    int    test_errors;
    int    passed;
    int    cycles;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    r2_top u_r2_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum_data  (sum_data),
        .sum_last  (sum_last)
    );

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic void fill_frame(input case_t tc);
        for (int i = 0; i < NPIX; i++) begin
            case (tc.kind)
                PAT_CONST: pixels[i] = tc.value;
                PAT_RAMP:  pixels[i] = pix_t'(tc.value + i);
                default:   pixels[i] = pix_t'($urandom);
            endcase
        end
    endfunction

    // Sum over every pixel at or above the row and at or left of the column.
    function automatic void build_model();
        sum_t acc;
        for (int r = 0; r < `R2_ROWS; r++) begin
            for (int c = 0; c < `R2_COLS; c++) begin
                acc = '0;
                for (int rr = 0; rr <= r; rr++) begin
                    for (int cc = 0; cc <= c; cc++) begin
                        acc = acc + sum_t'(pixels[rr * `R2_COLS + cc]);
                    end
                end
                expected[r * `R2_COLS + c] = acc;
            end
        end
    endfunction

    task automatic run_frame(input case_t tc);
        int   in_idx;
        int   out_idx;
        logic xfer;
        bit   finished;
        bit   start_again;
        in_idx = 0;
        out_idx = 0;
        finished = 0;
        start_again = 0;
        test_errors = 0;
        fill_frame(tc);
        build_model();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!finished) begin
            @(posedge clk);
            // Done only on the cycle after the final output leaves.
            check_flag("done", done, out_idx == NPIX);
            finished = done;
            xfer = pix_valid && pix_ready;
            if (xfer) begin
                in_idx++;
            end
            if (sum_valid && sum_ready) begin
                if (out_idx < NPIX) begin
                    check_sum("sum_data", sum_data, expected[out_idx]);
                    check_flag("sum_last", sum_last, out_idx == NPIX - 1);
                end else begin
                    $display("Extra output value after the end of frame %s", tc.name);
                    errors++;
                    test_errors++;
                end
                out_idx++;
            end
            if (!pix_valid || xfer) begin
                if (in_idx < NPIX && $urandom_range(99) >= VALID_GAP) begin
                    pix_valid <= 1'b1;
                    pix_data  <= pixels[in_idx];
                end else begin
                    pix_valid <= 1'b0;
                end
            end
            sum_ready <= ($urandom_range(99) >= tc.stall);
            // A second start in mid frame has to be ignored.
            if (!start_again && in_idx >= NPIX / 2) begin
                start <= 1'b1;
                start_again = 1;
            end else begin
                start <= 1'b0;
            end
        end
        @(posedge clk);
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        $display("%s %s errors %0d", (test_errors == 0) ? "PASS" : "FAIL", tc.name, test_errors);
        if (test_errors == 0) begin
            passed++;
        end
    endtask

    initial begin
        void'($urandom(32'hb811_5d9b));
        errors = 0;
        passed = 0;
        rst = 1'b1;
        start = 1'b0;
        pix_valid = 1'b0;
        pix_data = '0;
        sum_ready = 1'b0;
        cases[0] = '{"const_max", PAT_CONST, 8'd255, 0};
        cases[1] = '{"const_one_stall", PAT_CONST, 8'd1, 30};
        cases[2] = '{"ramp", PAT_RAMP, 8'd3, 0};
        cases[3] = '{"ramp_wrap_stall", PAT_RAMP, 8'd250, 50};
        cases[4] = '{"random", PAT_RANDOM, 8'd0, 0};
        cases[5] = '{"random_stall", PAT_RANDOM, 8'd0, 50};
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_errors = 0;
        repeat (4) begin
            @(posedge clk);
            check_flag("pix_ready", pix_ready, 1'b0);
            check_flag("sum_valid", sum_valid, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
        end
        $display("%s idle_after_reset errors %0d", (test_errors == 0) ? "PASS" : "FAIL",
                 test_errors);
        if (test_errors == 0) begin
            passed++;
        end
        for (int i = 0; i < NCASES; i++) begin
            run_frame(cases[i]);
        end
        errors += u_r2_top.u_chk.fail_cnt;
        $display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
                 NCASES + 1, passed, NCASES + 1 - passed, errors, u_r2_top.u_chk.fail_cnt);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run length bound.
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a frame did not complete", cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/r2_top.sv
`timescale 1ns/1ps
`default_nettype none

module r2_top import r2_pkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic start,
    output logic busy,
    output logic done,

    input  logic pix_valid,
    output logic pix_ready,
    input  pix_t pix_data,

    output logic sum_valid,
    input  logic sum_ready,
    output sum_t sum_data,
    output logic sum_last
);

    r2_ctrl_if ctl_if ();
    r2_line_if line_if ();

    r2_controller u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done),
        .ctl   (ctl_if.ctrl)
    );

    // Line flags drop on the controller's clear state.
    r2_line_buffer u_line (
        .clk   (clk),
        .rst   (rst),
        .clear (ctl_if.clear),
        .line  (line_if.mem)
    );

    r2_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .ctl       (ctl_if.dp),
        .line      (line_if.user),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum_data  (sum_data),
        .sum_last  (sum_last)
    );

endmodule

`default_nettype wire
